/* logic/misc_pkg.sv */
/*
 * Shared definitions for the badge misc register block.
 * Holds the register map, bus widths, the per-bank mask and reset tables
 * and the extension bank word layout. Modules refer to these by scoped name.
 */

package misc_pkg;

	// bus widths
	localparam int misc_data_w = 32;
	localparam int misc_addr_w = 7;
	// register index taken from byte address bits 6..2
	localparam int reg_idx_w = misc_addr_w - 2;

	// fixed registers
	localparam logic [reg_idx_w-1:0] reg_led = 5'd0;
	localparam logic [reg_idx_w-1:0] reg_btn = 5'd1;
	localparam logic [reg_idx_w-1:0] reg_soc_ver = 5'd2;
	localparam logic [reg_idx_w-1:0] reg_flash_sel = 5'd13;

	// io banks, each a group of five consecutive registers
	localparam int reg_bank_base = 17;
	localparam int bank_reg_span = 5;
	localparam int bank_in = 0;
	localparam int bank_out = 1;
	localparam int bank_oe = 2;
	localparam int bank_set = 3;
	localparam int bank_clr = 4;
	localparam int num_banks = 2;

	// bank 0 is the 30-bit header, bank 1 the sao/pmod/irda word
	localparam logic [num_banks-1:0][misc_data_w-1:0] bank_mask = {
		32'h40ff_3f3f,
		32'h3fff_ffff
	};

	// irda shutdown starts asserted
	localparam logic [num_banks-1:0][misc_data_w-1:0] bank_reset_out = {
		32'h4000_0000,
		32'h0000_0000
	};

	localparam logic [misc_data_w-1:0] soc_version = 32'h0;

	localparam int led_w = 16;
	localparam int led_pins = 9;

	// flash select writes carrying this in bits 31..8 trigger an fpga reload
	localparam logic [23:0] reload_key = 24'hd0f1a5;
	localparam logic [2:0] fsel_delay_load = 3'd7;

	// register index of one register inside a bank
	function automatic logic [reg_idx_w-1:0] bank_reg_idx(input int bank, input int offset);
		return reg_idx_w'(reg_bank_base + bank * bank_reg_span + offset);
	endfunction

	// extension bank word, seen raw or as connector fields
	typedef union packed {
		logic [misc_data_w-1:0] raw;
		struct packed {
			logic spare_31;
			logic irda_sd;
			logic [5:0] spare_29_24;
			logic [7:0] pmod;
			logic [1:0] spare_15_14;
			logic [5:0] sao2;
			logic [1:0] spare_7_6;
			logic [5:0] sao1;
		} f;
	} ext_word_u;

endpackage

/* logic/misc_write_decode.sv */
/*
 * Write side of the misc register block.
 * An accepted bus write is registered and turned into a single strobe for
 * one bank register or the flash sequencer, along with a copy of the data.
 * The LED and trace enable registers live here and load from that copy.
 */

module misc_write_decode (
	input  logic clk48m,
	input  logic rst,
	input  logic bus_strobe,
	input  logic bus_write,
	input  logic [misc_pkg::misc_addr_w-1:0] bus_addr,
	input  logic [misc_pkg::misc_data_w-1:0] bus_wdata,
	output logic [misc_pkg::num_banks-1:0] bank_wr_out,
	output logic [misc_pkg::num_banks-1:0] bank_wr_oe,
	output logic [misc_pkg::num_banks-1:0] bank_set,
	output logic [misc_pkg::num_banks-1:0] bank_clr,
	output logic fsel_write,
	output logic [misc_pkg::misc_data_w-1:0] wdata_q,
	output logic [misc_pkg::led_w-1:0] led,
	output logic trace_en
);

	logic [misc_pkg::reg_idx_w-1:0] wr_idx;
	logic wr_hit;
	logic [misc_pkg::num_banks-1:0] out_nxt;
	logic [misc_pkg::num_banks-1:0] oe_nxt;
	logic [misc_pkg::num_banks-1:0] set_nxt;
	logic [misc_pkg::num_banks-1:0] clr_nxt;
	logic led_nxt;
	logic ver_nxt;
	logic fsel_nxt;
	logic led_wr;
	logic ver_wr;

	// byte lane bits are ignored
	assign wr_idx = bus_addr[misc_pkg::misc_addr_w-1:2];
	assign wr_hit = bus_strobe && bus_write;

	always_comb begin
		led_nxt = wr_hit && (wr_idx == misc_pkg::reg_led);
		ver_nxt = wr_hit && (wr_idx == misc_pkg::reg_soc_ver);
		fsel_nxt = wr_hit && (wr_idx == misc_pkg::reg_flash_sel);
		for (int b = 0; b < misc_pkg::num_banks; b++) begin
			out_nxt[b] = wr_hit && (wr_idx == misc_pkg::bank_reg_idx(b, misc_pkg::bank_out));
			oe_nxt[b] = wr_hit && (wr_idx == misc_pkg::bank_reg_idx(b, misc_pkg::bank_oe));
			set_nxt[b] = wr_hit && (wr_idx == misc_pkg::bank_reg_idx(b, misc_pkg::bank_set));
			clr_nxt[b] = wr_hit && (wr_idx == misc_pkg::bank_reg_idx(b, misc_pkg::bank_clr));
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			bank_wr_out <= '0;
			bank_wr_oe <= '0;
			bank_set <= '0;
			bank_clr <= '0;
			fsel_write <= 1'b0;
			led_wr <= 1'b0;
			ver_wr <= 1'b0;
		end else begin
			bank_wr_out <= out_nxt;
			bank_wr_oe <= oe_nxt;
			bank_set <= set_nxt;
			bank_clr <= clr_nxt;
			fsel_write <= fsel_nxt;
			led_wr <= led_nxt;
			ver_wr <= ver_nxt;
		end
	end

	always_ff @(posedge clk48m) begin
		wdata_q <= bus_wdata;
	end

	// same one-cycle lag as the banks
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= '0;
			trace_en <= 1'b0;
		end else begin
			if (led_wr) begin
				led <= wdata_q[misc_pkg::led_w-1:0];
			end
			if (ver_wr) begin
				trace_en <= wdata_q[0];
			end
		end
	end

endmodule

/* logic/gpio_bank.sv */
/*
 * One general purpose io bank.
 * Keeps the output and output enable words. The output can be loaded,
 * or bits set or cleared; only bits in writable_mask are affected.
 */

module gpio_bank #(
	parameter logic [misc_pkg::misc_data_w-1:0] writable_mask = '1,
	parameter logic [misc_pkg::misc_data_w-1:0] reset_out = '0
) (
	input  logic clk48m,
	input  logic rst,
	input  logic wr_out,
	input  logic wr_oe,
	input  logic set,
	input  logic clr,
	input  logic [misc_pkg::misc_data_w-1:0] wdata,
	output logic [misc_pkg::misc_data_w-1:0] out,
	output logic [misc_pkg::misc_data_w-1:0] oe
);

	logic [misc_pkg::misc_data_w-1:0] wdata_m;

	assign wdata_m = wdata & writable_mask;

	// at most one of the strobes is high in any cycle
	always_ff @(posedge clk48m) begin
		if (rst) begin
			out <= reset_out;
			oe <= '0;
		end else begin
			if (wr_out) begin
				out <= wdata_m;
			end else if (set) begin
				out <= out | wdata_m;
			end else if (clr) begin
				out <= out & ~wdata_m;
			end
			if (wr_oe) begin
				oe <= wdata_m;
			end
		end
	end

endmodule

/* logic/misc_readback.sv */
/*
 * Read side of the misc register block.
 * A read strobe selects one register or bank word by index and registers it,
 * so data shows up with bus_rvalid one cycle after the strobe.
 * Set, clear and unused indices read as zero.
 */

module misc_readback (
	input  logic clk48m,
	input  logic rst,
	input  logic bus_strobe,
	input  logic bus_write,
	input  logic [misc_pkg::misc_addr_w-1:0] bus_addr,
	input  logic [7:0] btn,
	input  logic [misc_pkg::led_w-1:0] led,
	input  logic fsel_d,
	input  logic [misc_pkg::num_banks-1:0][misc_pkg::misc_data_w-1:0] bank_in,
	input  logic [misc_pkg::num_banks-1:0][misc_pkg::misc_data_w-1:0] bank_out,
	input  logic [misc_pkg::num_banks-1:0][misc_pkg::misc_data_w-1:0] bank_oe,
	output logic [misc_pkg::misc_data_w-1:0] bus_rdata,
	output logic bus_rvalid
);

	logic [misc_pkg::reg_idx_w-1:0] rd_idx;
	logic rd_hit;
	logic [misc_pkg::misc_data_w-1:0] rd_word;

	assign rd_idx = bus_addr[misc_pkg::misc_addr_w-1:2];
	assign rd_hit = bus_strobe && !bus_write;

	always_comb begin
		rd_word = '0;
		case (rd_idx)
			misc_pkg::reg_led: rd_word[misc_pkg::led_w-1:0] = led;
			// buttons are active low on the board
			misc_pkg::reg_btn: rd_word[7:0] = ~btn;
			misc_pkg::reg_soc_ver: rd_word = misc_pkg::soc_version;
			misc_pkg::reg_flash_sel: rd_word[0] = fsel_d;
			default: rd_word = '0;
		endcase
		for (int b = 0; b < misc_pkg::num_banks; b++) begin
			if (rd_idx == misc_pkg::bank_reg_idx(b, misc_pkg::bank_in)) begin
				// unconnected input bits read as zero
				rd_word = bank_in[b] & misc_pkg::bank_mask[b];
			end
			if (rd_idx == misc_pkg::bank_reg_idx(b, misc_pkg::bank_out)) begin
				rd_word = bank_out[b];
			end
			if (rd_idx == misc_pkg::bank_reg_idx(b, misc_pkg::bank_oe)) begin
				rd_word = bank_oe[b];
			end
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			bus_rvalid <= 1'b0;
		end else begin
			bus_rvalid <= rd_hit;
		end
	end

	// data holds between reads
	always_ff @(posedge clk48m) begin
		if (rd_hit) begin
			bus_rdata <= rd_word;
		end
	end

endmodule

/* logic/flash_reload_seq.sv */
/*
 * Flash select and fpga reload sequencer.
 * A flash select write latches the select bit and restarts a short countdown
 * that pulses the select flop clock. If the write carried the reload key,
 * programn is pulled low once the countdown ends and stays low until reset.
 */

module flash_reload_seq (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_write,
	input  logic [misc_pkg::misc_data_w-1:0] wdata,
	output logic fsel_d,
	output logic fsel_c,
	output logic programn
);

	logic [2:0] fsel_delay;
	logic reload_armed;
	logic fpga_reload;

	// select clock high for counts 5..3, two cycles after the load
	assign fsel_c = (fsel_delay == 3'd5) || (fsel_delay == 3'd4) || (fsel_delay == 3'd3);
	assign programn = !fpga_reload;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_d <= 1'b0;
			reload_armed <= 1'b0;
		end else if (fsel_write) begin
			fsel_d <= wdata[0];
			if (wdata[misc_pkg::misc_data_w-1:8] == misc_pkg::reload_key) begin
				reload_armed <= 1'b1;
			end
		end
	end

	// the select flop must settle before the fpga reloads
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay <= '0;
			fpga_reload <= 1'b0;
		end else begin
			if (fsel_write) begin
				fsel_delay <= misc_pkg::fsel_delay_load;
			end else if (fsel_delay != 3'd0) begin
				fsel_delay <= fsel_delay - 3'd1;
				if ((fsel_delay == 3'd1) && reload_armed) begin
					fpga_reload <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/misc_soc_top.sv */
/*
 * Top level of the misc register block.
 * Connects the write decoder, the io banks, the readback mux and the flash
 * sequencer, and maps bank words onto the header, sao, pmod and irda pins.
 */

module misc_soc_top (
	input  logic clk48m,
	input  logic rst,
	input  logic bus_strobe,
	input  logic bus_write,
	input  logic [misc_pkg::misc_addr_w-1:0] bus_addr,
	input  logic [misc_pkg::misc_data_w-1:0] bus_wdata,
	input  logic [7:0] btn,
	input  logic [29:0] genio_in,
	input  logic [5:0] sao1_in,
	input  logic [5:0] sao2_in,
	input  logic [7:0] pmod_in,
	output logic [misc_pkg::misc_data_w-1:0] bus_rdata,
	output logic bus_rvalid,
	output logic [misc_pkg::led_pins-1:0] led,
	output logic trace_en,
	output logic [29:0] genio_out,
	output logic [29:0] genio_oe,
	output logic [5:0] sao1_out,
	output logic [5:0] sao1_oe,
	output logic [5:0] sao2_out,
	output logic [5:0] sao2_oe,
	output logic [7:0] pmod_out,
	output logic [7:0] pmod_oe,
	output logic irda_sd,
	output logic fsel_d,
	output logic fsel_c,
	output logic programn
);

	logic [misc_pkg::num_banks-1:0] bank_wr_out;
	logic [misc_pkg::num_banks-1:0] bank_wr_oe;
	logic [misc_pkg::num_banks-1:0] bank_set;
	logic [misc_pkg::num_banks-1:0] bank_clr;
	logic fsel_write;
	logic [misc_pkg::misc_data_w-1:0] wdata_q;
	logic [misc_pkg::led_w-1:0] led_word;
	logic [misc_pkg::num_banks-1:0][misc_pkg::misc_data_w-1:0] bank_in;
	logic [misc_pkg::num_banks-1:0][misc_pkg::misc_data_w-1:0] bank_out;
	logic [misc_pkg::num_banks-1:0][misc_pkg::misc_data_w-1:0] bank_oe;
	misc_pkg::ext_word_u ext_in;
	misc_pkg::ext_word_u ext_out;
	misc_pkg::ext_word_u ext_oe;

	misc_write_decode u_write_decode (
		.clk48m(clk48m),
		.rst(rst),
		.bus_strobe(bus_strobe),
		.bus_write(bus_write),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bank_wr_out(bank_wr_out),
		.bank_wr_oe(bank_wr_oe),
		.bank_set(bank_set),
		.bank_clr(bank_clr),
		.fsel_write(fsel_write),
		.wdata_q(wdata_q),
		.led(led_word),
		.trace_en(trace_en)
	);

	for (genvar b = 0; b < misc_pkg::num_banks; b++) begin : g_bank
		gpio_bank #(
			.writable_mask(misc_pkg::bank_mask[b]),
			.reset_out(misc_pkg::bank_reset_out[b])
		) u_bank (
			.clk48m(clk48m),
			.rst(rst),
			.wr_out(bank_wr_out[b]),
			.wr_oe(bank_wr_oe[b]),
			.set(bank_set[b]),
			.clr(bank_clr[b]),
			.wdata(wdata_q),
			.out(bank_out[b]),
			.oe(bank_oe[b])
		);
	end

	misc_readback u_readback (
		.clk48m(clk48m),
		.rst(rst),
		.bus_strobe(bus_strobe),
		.bus_write(bus_write),
		.bus_addr(bus_addr),
		.btn(btn),
		.led(led_word),
		.fsel_d(fsel_d),
		.bank_in(bank_in),
		.bank_out(bank_out),
		.bank_oe(bank_oe),
		.bus_rdata(bus_rdata),
		.bus_rvalid(bus_rvalid)
	);

	flash_reload_seq u_flash_seq (
		.clk48m(clk48m),
		.rst(rst),
		.fsel_write(fsel_write),
		.wdata(wdata_q),
		.fsel_d(fsel_d),
		.fsel_c(fsel_c),
		.programn(programn)
	);

	// extension inputs gathered into the bank 1 word
	always_comb begin
		ext_in.raw = '0;
		ext_in.f.pmod = pmod_in;
		ext_in.f.sao2 = sao2_in;
		ext_in.f.sao1 = sao1_in;
	end

	assign bank_in[0] = {2'b00, genio_in};
	assign bank_in[1] = ext_in.raw;

	assign ext_out.raw = bank_out[1];
	assign ext_oe.raw = bank_oe[1];

	assign genio_out = bank_out[0][29:0];
	assign genio_oe = bank_oe[0][29:0];
	assign sao1_out = ext_out.f.sao1;
	assign sao1_oe = ext_oe.f.sao1;
	assign sao2_out = ext_out.f.sao2;
	assign sao2_oe = ext_oe.f.sao2;
	assign pmod_out = ext_out.f.pmod;
	assign pmod_oe = ext_oe.f.pmod;
	assign irda_sd = ext_out.f.irda_sd;

	// only the low LED bits reach pins
	assign led = led_word[misc_pkg::led_pins-1:0];

endmodule

/* verification/misc_tb.sv */
/*
 * Self-checking testbench for the misc register block.
 * Drives the register bus and pin inputs, keeps a register model and
 * compares pin states and bus reads with it. Reads are checked by a
 * separate process that watches bus_rvalid. Built with Verilator from src.f.
 */

module misc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int read_timeout = 20;
	localparam int reload_timeout = 40;

	logic clk48m;
	logic rst;
	logic bus_strobe;
	logic bus_write;
	logic [misc_pkg::misc_addr_w-1:0] bus_addr;
	logic [misc_pkg::misc_data_w-1:0] bus_wdata;
	logic [7:0] btn;
	logic [29:0] genio_in;
	logic [5:0] sao1_in;
	logic [5:0] sao2_in;
	logic [7:0] pmod_in;
	logic [misc_pkg::misc_data_w-1:0] bus_rdata;
	logic bus_rvalid;
	logic [misc_pkg::led_pins-1:0] led;
	logic trace_en;
	logic [29:0] genio_out;
	logic [29:0] genio_oe;
	logic [5:0] sao1_out;
	logic [5:0] sao1_oe;
	logic [5:0] sao2_out;
	logic [5:0] sao2_oe;
	logic [7:0] pmod_out;
	logic [7:0] pmod_oe;
	logic irda_sd;
	logic fsel_d;
	logic fsel_c;
	logic programn;

	// register model
	logic [misc_pkg::led_w-1:0] led_m;
	logic trace_m;
	logic fsel_m;
	logic [31:0] out_m [misc_pkg::num_banks];
	logic [31:0] oe_m [misc_pkg::num_banks];
	logic [31:0] rng_state;

	// reads waiting for their data
	logic [31:0] exp_q[$];
	string name_q[$];

	int errors;
	int checks;
	int tests;
	int test_errors_start;

	misc_soc_top u_misc_soc_top (
		.clk48m(clk48m),
		.rst(rst),
		.bus_strobe(bus_strobe),
		.bus_write(bus_write),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.btn(btn),
		.genio_in(genio_in),
		.sao1_in(sao1_in),
		.sao2_in(sao2_in),
		.pmod_in(pmod_in),
		.bus_rdata(bus_rdata),
		.bus_rvalid(bus_rvalid),
		.led(led),
		.trace_en(trace_en),
		.genio_out(genio_out),
		.genio_oe(genio_oe),
		.sao1_out(sao1_out),
		.sao1_oe(sao1_oe),
		.sao2_out(sao2_out),
		.sao2_oe(sao2_oe),
		.pmod_out(pmod_out),
		.pmod_oe(pmod_oe),
		.irda_sd(irda_sd),
		.fsel_d(fsel_d),
		.fsel_c(fsel_c),
		.programn(programn)
	);

	initial begin
		clk48m = 1'b0;
		forever begin
			#5 clk48m = ~clk48m;
		end
	end

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int bank_index(int b, int off);
		return misc_pkg::reg_bank_base + b * misc_pkg::bank_reg_span + off;
	endfunction

	// bank output after a load, set or clear; other offsets leave it alone
	function automatic logic [31:0] bank_after(int b, int off, logic [31:0] old,
			logic [31:0] data);
		logic [31:0] m;
		logic [31:0] r;
		m = data & misc_pkg::bank_mask[b];
		r = old;
		if (off == misc_pkg::bank_out) begin
			r = m;
		end else if (off == misc_pkg::bank_set) begin
			r = old | m;
		end else if (off == misc_pkg::bank_clr) begin
			r = old & ~m;
		end
		return r;
	endfunction

	// raw input word a bank sees from its pins
	function automatic logic [31:0] bank_input(int b);
		misc_pkg::ext_word_u u;
		u.raw = '0;
		if (b == 0) begin
			u.raw = {2'b00, genio_in};
		end else begin
			u.f.sao1 = sao1_in;
			u.f.sao2 = sao2_in;
			u.f.pmod = pmod_in;
		end
		return u.raw;
	endfunction

	function automatic logic [31:0] expected_read(int idx);
		logic [31:0] w;
		int b;
		int off;
		w = '0;
		b = (idx - misc_pkg::reg_bank_base) / misc_pkg::bank_reg_span;
		off = (idx - misc_pkg::reg_bank_base) % misc_pkg::bank_reg_span;
		if (idx == int'(misc_pkg::reg_led)) begin
			w = {16'h0, led_m};
		end else if (idx == int'(misc_pkg::reg_btn)) begin
			w = {24'h0, ~btn};
		end else if (idx == int'(misc_pkg::reg_soc_ver)) begin
			w = misc_pkg::soc_version;
		end else if (idx == int'(misc_pkg::reg_flash_sel)) begin
			w = {31'h0, fsel_m};
		end else if (idx >= misc_pkg::reg_bank_base && b < misc_pkg::num_banks) begin
			if (off == misc_pkg::bank_in) begin
				w = bank_input(b) & misc_pkg::bank_mask[b];
			end else if (off == misc_pkg::bank_out) begin
				w = out_m[b];
			end else if (off == misc_pkg::bank_oe) begin
				w = oe_m[b];
			end
		end
		return w;
	endfunction

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	task automatic fail_timeout(string what);
		$display("timeout while waiting for %s", what);
		$display("Errors found");
		$finish;
	endtask

	// strobe a write and update the model, returns just after the strobe edge
	task automatic issue_write(int idx, logic [31:0] data);
		logic [31:0] rnd;
		int b;
		int off;
		rnd = xorshift32();
		bus_strobe = 1'b1;
		bus_write = 1'b1;
		bus_addr = {5'(idx), rnd[1:0]};
		bus_wdata = data;
		@(posedge clk48m);
		#1;
		bus_strobe = 1'b0;
		bus_write = 1'b0;
		b = (idx - misc_pkg::reg_bank_base) / misc_pkg::bank_reg_span;
		off = (idx - misc_pkg::reg_bank_base) % misc_pkg::bank_reg_span;
		if (idx == int'(misc_pkg::reg_led)) begin
			led_m = data[misc_pkg::led_w-1:0];
		end else if (idx == int'(misc_pkg::reg_soc_ver)) begin
			trace_m = data[0];
		end else if (idx == int'(misc_pkg::reg_flash_sel)) begin
			fsel_m = data[0];
		end else if (idx >= misc_pkg::reg_bank_base && b < misc_pkg::num_banks) begin
			if (off == misc_pkg::bank_oe) begin
				oe_m[b] = data & misc_pkg::bank_mask[b];
			end else begin
				out_m[b] = bank_after(b, off, out_m[b], data);
			end
		end
	endtask

	// registers take effect two edges after the strobe
	task automatic write_reg(int idx, logic [31:0] data);
		issue_write(idx, data);
		repeat (2) @(posedge clk48m);
		#1;
	endtask

	task automatic read_reg(int idx, string name);
		int cycles;
		exp_q.push_back(expected_read(idx));
		name_q.push_back(name);
		bus_strobe = 1'b1;
		bus_write = 1'b0;
		bus_addr = {5'(idx), 2'b00};
		@(posedge clk48m);
		#1;
		bus_strobe = 1'b0;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < read_timeout) begin
			@(posedge clk48m);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			fail_timeout("read data valid");
		end else begin
			#1;
		end
	endtask

	task automatic end_test(string name);
		tests++;
		if (errors == test_errors_start) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d mismatches", tests, name, errors - test_errors_start);
		end
		test_errors_start = errors;
	endtask

	// read data is stable at the falling edge
	initial begin
		forever begin
			@(negedge clk48m);
			if (bus_rvalid === 1'b1) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("read data came back with no read pending");
				end else begin
					check(name_q.pop_front(), exp_q.pop_front(), bus_rdata);
				end
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] data;
		logic [8:0] pulse;
		logic [8:0] exp_pulse;
		misc_pkg::ext_word_u ext_o;
		misc_pkg::ext_word_u ext_e;
		int off;
		int cnt;
		int lows;
		int cycles;
		rst = 1'b1;
		bus_strobe = 1'b0;
		bus_write = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		btn = 8'h00;
		genio_in = '0;
		sao1_in = '0;
		sao2_in = '0;
		pmod_in = '0;
		rng_state = 32'ha724;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors_start = 0;
		led_m = '0;
		trace_m = 1'b0;
		fsel_m = 1'b0;
		for (int b = 0; b < misc_pkg::num_banks; b++) begin
			out_m[b] = misc_pkg::bank_reset_out[b];
			oe_m[b] = '0;
		end
		repeat (2) @(posedge clk48m);
		#1;
		rst = 1'b0;

		check("reset programn", 32'h1, 32'(programn));
		check("reset fsel_c", 32'h0, 32'(fsel_c));
		check("reset trace_en", 32'h0, 32'(trace_en));
		check("reset genio_oe", 32'h0, 32'(genio_oe));
		check("reset ext oe", 32'h0, 32'({sao1_oe, sao2_oe, pmod_oe}));
		check("reset irda_sd", 32'h1, 32'(irda_sd));
		read_reg(int'(misc_pkg::reg_led), "reset led read");
		read_reg(bank_index(0, misc_pkg::bank_out), "reset header out read");
		read_reg(bank_index(1, misc_pkg::bank_out), "reset ext out read");
		read_reg(3, "unmapped read");
		end_test("reset state");

		rnd = xorshift32();
		write_reg(int'(misc_pkg::reg_led), rnd);
		write_reg(int'(misc_pkg::reg_soc_ver), 32'h1);
		rnd = xorshift32();
		btn = rnd[7:0];
		check("led pins", 32'(led_m[misc_pkg::led_pins-1:0]), 32'(led));
		check("trace_en", 32'(trace_m), 32'(trace_en));
		read_reg(int'(misc_pkg::reg_led), "led read");
		read_reg(int'(misc_pkg::reg_btn), "button read");
		read_reg(int'(misc_pkg::reg_soc_ver), "version read");
		end_test("simple registers");

		for (int i = 0; i < 12; i++) begin
			rnd = xorshift32();
			off = misc_pkg::bank_out + int'(rnd[1:0]);
			rnd = xorshift32();
			genio_in = rnd[29:0];
			data = xorshift32();
			write_reg(bank_index(0, off), data);
			check("genio_out", 32'(out_m[0][29:0]), 32'(genio_out));
			check("genio_oe", 32'(oe_m[0][29:0]), 32'(genio_oe));
			read_reg(bank_index(0, misc_pkg::bank_in), "header in read");
			read_reg(bank_index(0, misc_pkg::bank_out), "header out read");
			read_reg(bank_index(0, misc_pkg::bank_oe), "header oe read");
			read_reg(bank_index(0, misc_pkg::bank_set), "header set read");
			read_reg(bank_index(0, misc_pkg::bank_clr), "header clr read");
		end
		end_test("header bank");

		for (int i = 0; i < 12; i++) begin
			rnd = xorshift32();
			off = misc_pkg::bank_out + int'(rnd[1:0]);
			rnd = xorshift32();
			sao1_in = rnd[5:0];
			sao2_in = rnd[13:8];
			pmod_in = rnd[23:16];
			data = xorshift32();
			write_reg(bank_index(1, off), data);
			ext_o.raw = out_m[1];
			ext_e.raw = oe_m[1];
			check("sao1 out oe", 32'({ext_o.f.sao1, ext_e.f.sao1}), 32'({sao1_out, sao1_oe}));
			check("sao2 out oe", 32'({ext_o.f.sao2, ext_e.f.sao2}), 32'({sao2_out, sao2_oe}));
			check("pmod out oe", 32'({ext_o.f.pmod, ext_e.f.pmod}), 32'({pmod_out, pmod_oe}));
			check("irda_sd", 32'(ext_o.f.irda_sd), 32'(irda_sd));
			read_reg(bank_index(1, misc_pkg::bank_in), "ext in read");
			read_reg(bank_index(1, misc_pkg::bank_out), "ext out read");
			read_reg(bank_index(1, misc_pkg::bank_oe), "ext oe read");
		end
		end_test("extension bank");

		// counter loads 7 at edge 1, so after edge k it holds 8 - k
		issue_write(int'(misc_pkg::reg_flash_sel), 32'h0000_0001);
		pulse = '0;
		exp_pulse = '0;
		for (int k = 0; k <= 8; k++) begin
			@(negedge clk48m);
			pulse[k] = fsel_c;
			cnt = (k >= 1) ? 8 - k : 0;
			exp_pulse[k] = (cnt >= 3 && cnt <= 5);
		end
		check("fsel_c pulse", 32'(exp_pulse), 32'(pulse));
		lows = 0;
		for (int k = 0; k < 20; k++) begin
			@(negedge clk48m);
			if (programn !== 1'b1) begin
				lows++;
			end
		end
		check("programn without key", 32'h0, 32'(lows));
		@(posedge clk48m);
		#1;
		check("fsel_d pin", 32'(fsel_m), 32'(fsel_d));
		read_reg(int'(misc_pkg::reg_flash_sel), "flash select read");
		end_test("flash select without key");

		issue_write(int'(misc_pkg::reg_flash_sel), {misc_pkg::reload_key, 8'h01});
		cycles = 0;
		while (programn === 1'b1 && cycles < reload_timeout) begin
			@(posedge clk48m);
			#1;
			cycles++;
		end
		if (programn !== 1'b0) begin
			fail_timeout("programn to go low");
		end else begin
			repeat (10) @(posedge clk48m);
			#1;
			check("programn held low", 32'h0, 32'(programn));
			end_test("keyed reload");

			$display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
			if (errors == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
			$finish;
		end
	end

endmodule

/* src.f */
logic/misc_pkg.sv
logic/misc_write_decode.sv
logic/gpio_bank.sv
logic/misc_readback.sv
logic/flash_reload_seq.sv
logic/misc_soc_top.sv
verification/misc_tb.sv

/* Makefile */
# Verilator simulation of the misc register block

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/Vmisc_tb: src.f $(shell cat src.f)
	verilator --binary --timing -f src.f --top-module misc_tb -Mdir obj_dir

test: obj_dir/Vmisc_tb
	./obj_dir/Vmisc_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "No errors" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
